// ==== common/mips_config.svh ====
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// instruction fields
`define OPCODE_W 6
`define FUNCT_W  6

// control field widths
`define CLASS_W  4
`define STATE_W  5
`define ALUOP_W  3
`define PCSRC_W  3

// opcodes
`define OP_RTYPE 6'h00
`define OP_J     6'h02
`define OP_JAL   6'h03
`define OP_BEQ   6'h04
`define OP_BNE   6'h05
`define OP_ADDI  6'h08
`define OP_ADDIU 6'h09
`define OP_LB    6'h20
`define OP_LH    6'h21
`define OP_LW    6'h23
`define OP_SB    6'h28
`define OP_SH    6'h29
`define OP_SW    6'h2b

// funct codes under OP_RTYPE
`define FN_JR    6'h08
`define FN_ADD   6'h20
`define FN_AND   6'h24

// pc mux input wired to the exception vector
`define EXC_VEC_SEL 3'd4

`endif

// ==== common/mipsCtrlPkg.sv ====
`include "mips_config.svh"

package mipsCtrlPkg;

    // load and store split by access size to fill the 16 codes
    typedef enum logic [`CLASS_W-1:0] {
        clsAddR, clsAndR, clsAddi, clsAddiu,
        clsLoadWord, clsLoadHalf, clsLoadByte,
        clsStoreWord, clsStoreHalf, clsStoreByte,
        clsBeq, clsBne, clsJump, clsJal, clsJr,
        clsIllegal
    } instrClass_t;

    typedef enum logic [`STATE_W-1:0] {
        sReset, sFetch, sFetchWait, sIrLoad, sDecode,
        sAluReg, sAluImm, sWriteRd, sWriteRt,
        sAddrCalc, sMemRead, sMemWait, sMdrLoad, sLoadWrite, sMemWrite,
        sBranch, sLink, sJump, sJumpReg,
        sExcSave, sExcVector
    } ctrlState_t;

    typedef enum logic [`ALUOP_W-1:0] {
        aluAdd, aluSub, aluAnd, aluPassA
    } aluOp_t;

    typedef enum logic {
        srcAPc, srcARegA
    } aluSrcA_t;

    typedef enum logic [1:0] {
        srcBRegB, srcBFour, srcBSignImm, srcBBranchOff
    } aluSrcB_t;

    typedef enum logic [`PCSRC_W-1:0] {
        pcAluResult  = 3'd0,
        pcAluOut     = 3'd1,
        pcJumpTarget = 3'd2,
        pcRegA       = 3'd3,
        pcExcVector  = `EXC_VEC_SEL
    } pcSrc_t;

    typedef enum logic [1:0] {
        dstRt, dstRd, dstRa
    } regDst_t;

    typedef enum logic [1:0] {
        wbAluOut, wbMemData, wbPcValue // wb = register write-back source
    } memToReg_t;

    typedef enum logic [1:0] {
        sizeWord, sizeHalf, sizeByte
    } accessSize_t;

    typedef enum logic {
        causeOverflow, causeIllegal
    } excCause_t;

endpackage

// ==== logic/opcodeDecoder.sv ====
`include "mips_config.svh"

module opcodeDecoder
    import mipsCtrlPkg::*;
(
    input  logic [`OPCODE_W-1:0] opcode,
    input  logic [`FUNCT_W-1:0]  funct,
    output instrClass_t          instrClass
);

    instrClass_t rClass;

    // r-type is told apart by funct alone
    always_comb begin
        case (funct)
            `FN_ADD: rClass = clsAddR;
            `FN_AND: rClass = clsAndR;
            `FN_JR:  rClass = clsJr;
            default: rClass = clsIllegal;
        endcase
    end

    always_comb begin
        case (opcode)
            `OP_RTYPE: instrClass = rClass;
            `OP_ADDI:  instrClass = clsAddi;
            `OP_ADDIU: instrClass = clsAddiu;
            `OP_LW:    instrClass = clsLoadWord;
            `OP_LH:    instrClass = clsLoadHalf;
            `OP_LB:    instrClass = clsLoadByte;
            `OP_SW:    instrClass = clsStoreWord;
            `OP_SH:    instrClass = clsStoreHalf;
            `OP_SB:    instrClass = clsStoreByte;
            `OP_BEQ:   instrClass = clsBeq;
            `OP_BNE:   instrClass = clsBne;
            `OP_J:     instrClass = clsJump;
            `OP_JAL:   instrClass = clsJal;
            default:   instrClass = clsIllegal; // undefined opcode
        endcase
    end

endmodule

// ==== control/ctrlSequencer.sv ====
module ctrlSequencer
    import mipsCtrlPkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  instrClass_t instrClass,
    input  logic        overflow,
    output ctrlState_t  state
);

    ctrlState_t nextState;
    logic       isLoad;
    logic       isStore;

    always_comb begin
        isLoad  = 1'b0;
        isStore = 1'b0;
        case (instrClass)
            clsLoadWord, clsLoadHalf, clsLoadByte:    isLoad  = 1'b1;
            clsStoreWord, clsStoreHalf, clsStoreByte: isStore = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= sReset;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = sReset;
        case (state)
            sReset:     nextState = sFetch;
            sFetch:     nextState = sFetchWait;
            sFetchWait: nextState = sIrLoad; // instruction word arrives
            sIrLoad:    nextState = sDecode;
            sDecode: begin
                if (isLoad || isStore) begin
                    nextState = sAddrCalc;
                end else begin
                    case (instrClass)
                        clsAddR, clsAndR:   nextState = sAluReg;
                        clsAddi, clsAddiu:  nextState = sAluImm;
                        clsBeq, clsBne:     nextState = sBranch;
                        clsJump:            nextState = sJump;
                        clsJal:             nextState = sLink;
                        clsJr:              nextState = sJumpReg;
                        default:            nextState = sExcSave;
                    endcase
                end
            end
            sAluReg: begin
                // only add traps on overflow
                if (instrClass == clsAddR && overflow) begin
                    nextState = sExcSave;
                end else begin
                    nextState = sWriteRd;
                end
            end
            sAluImm: begin
                if (instrClass == clsAddi && overflow) begin
                    nextState = sExcSave;
                end else begin
                    nextState = sWriteRt; // addiu ignores the flag
                end
            end
            sWriteRd:   nextState = sFetch;
            sWriteRt:   nextState = sFetch;
            sAddrCalc:  nextState = isLoad ? sMemRead : sMemWrite;
            sMemRead:   nextState = sMemWait;
            sMemWait:   nextState = sMdrLoad;
            sMdrLoad:   nextState = sLoadWrite;
            sLoadWrite: nextState = sFetch;
            sMemWrite:  nextState = sFetch;
            sBranch:    nextState = sFetch;
            sLink:      nextState = sJump;
            sJump:      nextState = sFetch;
            sJumpReg:   nextState = sFetch;
            sExcSave:   nextState = sExcVector;
            sExcVector: nextState = sFetch;
            default:    nextState = sReset;
        endcase
    end

    stateLegal: assert property (
        @(posedge clk) disable iff (!rstN)
        state inside {[sReset:sExcVector]}
    ) else $error("state register holds an unlisted code");

    excVectorFollows: assert property (
        @(posedge clk) disable iff (!rstN)
        state == sExcSave |=> state == sExcVector
    ) else $error("sExcSave not followed by sExcVector");

endmodule

// ==== control/ctrlSignalEncoder.sv ====
module ctrlSignalEncoder
    import mipsCtrlPkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  ctrlState_t  state,
    input  instrClass_t instrClass,
    output logic        pcWrite,
    output logic        pcWriteCond,
    output logic        eqOrNe,
    output logic        irWrite,
    output logic        memRead,
    output logic        memWrite,
    output accessSize_t memSize,
    output logic        regWrite,
    output regDst_t     regDst,
    output memToReg_t   memToReg,
    output logic        regALoad,
    output logic        regBLoad,
    output aluSrcA_t    aluSrcA,
    output aluSrcB_t    aluSrcB,
    output aluOp_t      aluOp,
    output logic        aluOutWrite,
    output logic        mdrLoad,
    output pcSrc_t      pcSrc,
    output logic        epcWrite,
    output excCause_t   excCause
);

    accessSize_t classSize;

    always_comb begin
        case (instrClass)
            clsLoadHalf, clsStoreHalf: classSize = sizeHalf;
            clsLoadByte, clsStoreByte: classSize = sizeByte;
            default:                   classSize = sizeWord;
        endcase
    end

    always_comb begin
        pcWrite     = 1'b0;
        pcWriteCond = 1'b0;
        eqOrNe      = 1'b0;
        irWrite     = 1'b0;
        memRead     = 1'b0;
        memWrite    = 1'b0;
        memSize     = sizeWord;
        regWrite    = 1'b0;
        regDst      = dstRt;
        memToReg    = wbAluOut;
        regALoad    = 1'b0;
        regBLoad    = 1'b0;
        aluSrcA     = srcAPc;
        aluSrcB     = srcBRegB;
        aluOp       = aluAdd;
        aluOutWrite = 1'b0;
        mdrLoad     = 1'b0;
        pcSrc       = pcAluResult;
        epcWrite    = 1'b0;
        excCause    = causeOverflow;
        case (state)
            sFetch: begin
                pcWrite = 1'b1; // pc + 4
                memRead = 1'b1;
                aluSrcB = srcBFour;
            end
            sIrLoad: irWrite = 1'b1;
            sDecode: begin
                regALoad    = 1'b1;
                regBLoad    = 1'b1;
                aluSrcB     = srcBBranchOff; // branch target ahead of time
                aluOutWrite = 1'b1;
            end
            sAluReg: begin
                aluSrcA     = srcARegA;
                aluOp       = (instrClass == clsAndR) ? aluAnd : aluAdd;
                aluOutWrite = 1'b1;
            end
            sAluImm, sAddrCalc: begin
                aluSrcA     = srcARegA;
                aluSrcB     = srcBSignImm;
                aluOutWrite = 1'b1;
            end
            sWriteRd: begin
                regWrite = 1'b1;
                regDst   = dstRd;
            end
            sWriteRt: regWrite = 1'b1;
            sMemRead: begin
                memRead = 1'b1;
                memSize = classSize;
            end
            sMdrLoad: begin
                mdrLoad = 1'b1;
                memSize = classSize;
            end
            sLoadWrite: begin
                regWrite = 1'b1;
                memToReg = wbMemData;
                memSize  = classSize; // sign extension of sub-word data
            end
            sMemWrite: begin
                memWrite = 1'b1;
                memSize  = classSize;
            end
            sBranch: begin
                pcWriteCond = 1'b1;
                aluSrcA     = srcARegA;
                aluOp       = aluSub;
                pcSrc       = pcAluOut;
                eqOrNe      = (instrClass == clsBeq);
            end
            sLink: begin
                regWrite = 1'b1;
                regDst   = dstRa;
                memToReg = wbPcValue;
            end
            sJump: begin
                pcWrite = 1'b1;
                pcSrc   = pcJumpTarget;
            end
            sJumpReg: begin
                pcWrite = 1'b1;
                pcSrc   = pcRegA;
            end
            sExcSave: begin
                epcWrite = 1'b1;
                aluSrcB  = srcBFour;
                aluOp    = aluSub; // pc was already advanced in fetch
                excCause = (instrClass == clsIllegal) ? causeIllegal : causeOverflow;
            end
            sExcVector: begin
                pcWrite = 1'b1;
                pcSrc   = pcExcVector;
            end
            default: ;
        endcase
    end

    pcWriteExclusive: assert property (
        @(posedge clk) disable iff (!rstN)
        !(pcWrite && pcWriteCond)
    ) else $error("pcWrite and pcWriteCond both active");

    memAccessExclusive: assert property (
        @(posedge clk) disable iff (!rstN)
        !(memRead && memWrite)
    ) else $error("memRead and memWrite both active");

endmodule

// ==== control/controlUnit.sv ====
`include "mips_config.svh"

module controlUnit
    import mipsCtrlPkg::*;
(
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [`OPCODE_W-1:0] opcode,
    input  logic [`FUNCT_W-1:0]  funct,
    input  logic                 overflow,
    output logic                 pcWrite,
    output logic                 pcWriteCond,
    output logic                 eqOrNe,
    output logic                 irWrite,
    output logic                 memRead,
    output logic                 memWrite,
    output accessSize_t          memSize,
    output logic                 regWrite,
    output regDst_t              regDst,
    output memToReg_t            memToReg,
    output logic                 regALoad,
    output logic                 regBLoad,
    output aluSrcA_t             aluSrcA,
    output aluSrcB_t             aluSrcB,
    output aluOp_t               aluOp,
    output logic                 aluOutWrite,
    output logic                 mdrLoad,
    output pcSrc_t               pcSrc,
    output logic                 epcWrite,
    output excCause_t            excCause
);

    instrClass_t instrClass;
    ctrlState_t  state;

    opcodeDecoder decoder0 (
        .opcode     (opcode),
        .funct      (funct),
        .instrClass (instrClass)
    );

    ctrlSequencer seq0 (
        .clk        (clk),
        .rstN       (rstN),
        .instrClass (instrClass),
        .overflow   (overflow),
        .state      (state)
    );

    ctrlSignalEncoder enc0 (
        .clk         (clk),
        .rstN        (rstN),
        .state       (state),
        .instrClass  (instrClass),
        .pcWrite     (pcWrite),
        .pcWriteCond (pcWriteCond),
        .eqOrNe      (eqOrNe),
        .irWrite     (irWrite),
        .memRead     (memRead),
        .memWrite    (memWrite),
        .memSize     (memSize),
        .regWrite    (regWrite),
        .regDst      (regDst),
        .memToReg    (memToReg),
        .regALoad    (regALoad),
        .regBLoad    (regBLoad),
        .aluSrcA     (aluSrcA),
        .aluSrcB     (aluSrcB),
        .aluOp       (aluOp),
        .aluOutWrite (aluOutWrite),
        .mdrLoad     (mdrLoad),
        .pcSrc       (pcSrc),
        .epcWrite    (epcWrite),
        .excCause    (excCause)
    );

endmodule

// ==== sim/ctrlModel.svh ====
`ifndef CTRL_MODEL_SVH
`define CTRL_MODEL_SVH

// reference model stepping one state per clock
ctrlState_t  modelState;
instrClass_t modelClass; // class of the word held in the IR

function automatic logic isLoad(input instrClass_t c);
    return c inside {clsLoadWord, clsLoadHalf, clsLoadByte};
endfunction

function automatic ctrlState_t modelNext(input ctrlState_t s, input instrClass_t c,
                                         input logic ovf);
    case (s)
        sFetch:     return sFetchWait;
        sFetchWait: return sIrLoad;
        sIrLoad:    return sDecode;
        sDecode: begin
            case (c)
                clsAddR, clsAndR:  return sAluReg;
                clsAddi, clsAddiu: return sAluImm;
                clsBeq, clsBne:    return sBranch;
                clsJump:           return sJump;
                clsJal:            return sLink;
                clsJr:             return sJumpReg;
                clsLoadWord, clsLoadHalf, clsLoadByte,
                clsStoreWord, clsStoreHalf, clsStoreByte:
                    return sAddrCalc;
                default:           return sExcSave;
            endcase
        end
        sAluReg:    return (c == clsAddR && ovf) ? sExcSave : sWriteRd;
        sAluImm:    return (c == clsAddi && ovf) ? sExcSave : sWriteRt; // addiu never traps
        sAddrCalc:  return isLoad(c) ? sMemRead : sMemWrite;
        sMemRead:   return sMemWait;
        sMemWait:   return sMdrLoad;
        sMdrLoad:   return sLoadWrite;
        sLink:      return sJump;
        sExcSave:   return sExcVector;
        default:    return sFetch; // last step of every path
    endcase
endfunction

// size only shows in the memory states
function automatic accessSize_t expSize(input ctrlState_t s, input instrClass_t c);
    if (!(s inside {sMemRead, sMdrLoad, sLoadWrite, sMemWrite})) begin
        return sizeWord;
    end
    case (c)
        clsLoadHalf, clsStoreHalf: return sizeHalf;
        clsLoadByte, clsStoreByte: return sizeByte;
        default:                   return sizeWord;
    endcase
endfunction

function automatic aluSrcB_t expSrcB(input ctrlState_t s);
    case (s)
        sFetch, sExcSave:   return srcBFour;
        sDecode:            return srcBBranchOff;
        sAluImm, sAddrCalc: return srcBSignImm;
        default:            return srcBRegB;
    endcase
endfunction

function automatic aluOp_t expAluOp(input ctrlState_t s, input instrClass_t c);
    case (s)
        sAluReg:           return (c == clsAndR) ? aluAnd : aluAdd;
        sBranch, sExcSave: return aluSub;
        default:           return aluAdd;
    endcase
endfunction

function automatic pcSrc_t expPcSrc(input ctrlState_t s);
    case (s)
        sBranch:    return pcAluOut;
        sJump:      return pcJumpTarget;
        sJumpReg:   return pcRegA;
        sExcVector: return pcExcVector;
        default:    return pcAluResult;
    endcase
endfunction

`endif

// ==== sim/controlUnitTb.sv ====
`include "mips_config.svh"

module controlUnitTb
    import mipsCtrlPkg::*;
();

    localparam int NUM_INSTR    = 200;
    localparam int WORST_CYCLES = 9; // fetch/decode plus a load
    localparam int RESET_CYCLES = 4;
    localparam int CYCLE_LIMIT  = NUM_INSTR * WORST_CYCLES + 700; // slack over worst case

    logic                 clk;
    logic                 rstN;
    logic [`OPCODE_W-1:0] opcode;
    logic [`FUNCT_W-1:0]  funct;
    logic                 overflow;
    logic                 pcWrite, pcWriteCond, eqOrNe, irWrite, memRead, memWrite;
    logic                 regWrite, regALoad, regBLoad, aluOutWrite, mdrLoad, epcWrite;
    accessSize_t          memSize;
    regDst_t              regDst;
    memToReg_t            memToReg;
    aluSrcA_t             aluSrcA;
    aluSrcB_t             aluSrcB;
    aluOp_t               aluOp;
    pcSrc_t               pcSrc;
    excCause_t            excCause;
    logic [31:0]          lfsrState;
    int                   doneCount;

    // slots 0..14 are legal and slot 15 stands for an illegal word
    logic [5:0]  opTable [16] = '{`OP_RTYPE, `OP_RTYPE, `OP_RTYPE, `OP_ADDI, `OP_ADDIU,
        `OP_LW, `OP_LH, `OP_LB, `OP_SW, `OP_SH, `OP_SB, `OP_BEQ, `OP_BNE, `OP_J, `OP_JAL, 6'h3f};
    logic [5:0]  fnTable [3] = '{`FN_ADD, `FN_AND, `FN_JR};
    instrClass_t clsTable [16] = '{clsAddR, clsAndR, clsJr, clsAddi, clsAddiu,
        clsLoadWord, clsLoadHalf, clsLoadByte, clsStoreWord, clsStoreHalf, clsStoreByte,
        clsBeq, clsBne, clsJump, clsJal, clsIllegal};
    logic [5:0]  badOp [4] = '{6'h3f, 6'h0f, `OP_RTYPE, `OP_RTYPE};
    logic [5:0]  badFn [2] = '{6'h00, 6'h18}; // sll and mult are both dropped

    `include "ctrlModel.svh"

    controlUnit dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsrState[0]};
            lfsrState = (lfsrState >> 1) ^ (lfsrState[0] ? 32'h80200003 : 32'h0);
        end
        return val;
    endfunction

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic mismatch(input string what, input string got, input string exp);
        failRun($sformatf("MISMATCH at time %0t: %s is %s, expected %s in state %s",
            $time, what, got, exp, modelState.name()));
    endtask

    task automatic checkBit(input string what, input logic got, input logic exp);
        if (got !== exp) mismatch(what, $sformatf("%b", got), $sformatf("%b", exp));
    endtask

    task automatic checkSize(input accessSize_t got, input accessSize_t exp);
        if (got !== exp) mismatch("memSize", got.name(), exp.name());
    endtask

    task automatic checkRegDst(input regDst_t got, input regDst_t exp);
        if (got !== exp) mismatch("regDst", got.name(), exp.name());
    endtask

    task automatic checkMemToReg(input memToReg_t got, input memToReg_t exp);
        if (got !== exp) mismatch("memToReg", got.name(), exp.name());
    endtask

    task automatic checkSrcA(input aluSrcA_t got, input aluSrcA_t exp);
        if (got !== exp) mismatch("aluSrcA", got.name(), exp.name());
    endtask

    task automatic checkSrcB(input aluSrcB_t got, input aluSrcB_t exp);
        if (got !== exp) mismatch("aluSrcB", got.name(), exp.name());
    endtask

    task automatic checkAluOp(input aluOp_t got, input aluOp_t exp);
        if (got !== exp) mismatch("aluOp", got.name(), exp.name());
    endtask

    task automatic checkPcSrc(input pcSrc_t got, input pcSrc_t exp);
        if (got !== exp) mismatch("pcSrc", got.name(), exp.name());
    endtask

    task automatic checkCause(input excCause_t got, input excCause_t exp);
        if (got !== exp) mismatch("excCause", got.name(), exp.name());
    endtask

    task automatic checkOutputs();
        ctrlState_t  st;
        instrClass_t cls;
        st  = modelState;
        cls = modelClass;
        checkBit("pcWrite", pcWrite, st inside {sFetch, sJump, sJumpReg, sExcVector});
        checkBit("pcWriteCond", pcWriteCond, st == sBranch);
        checkBit("eqOrNe", eqOrNe, st == sBranch && cls == clsBeq);
        checkBit("irWrite", irWrite, st == sIrLoad);
        checkBit("memRead", memRead, st inside {sFetch, sMemRead});
        checkBit("memWrite", memWrite, st == sMemWrite);
        checkSize(memSize, expSize(st, cls));
        checkBit("regWrite", regWrite, st inside {sWriteRd, sWriteRt, sLoadWrite, sLink});
        checkRegDst(regDst, (st == sWriteRd) ? dstRd : (st == sLink) ? dstRa : dstRt);
        checkMemToReg(memToReg, (st == sLoadWrite) ? wbMemData :
                                (st == sLink) ? wbPcValue : wbAluOut);
        checkBit("regALoad", regALoad, st == sDecode);
        checkBit("regBLoad", regBLoad, st == sDecode);
        checkSrcA(aluSrcA, (st inside {sAluReg, sAluImm, sAddrCalc, sBranch}) ? srcARegA : srcAPc);
        checkSrcB(aluSrcB, expSrcB(st));
        checkAluOp(aluOp, expAluOp(st, cls));
        checkBit("aluOutWrite", aluOutWrite, st inside {sDecode, sAluReg, sAluImm, sAddrCalc});
        checkBit("mdrLoad", mdrLoad, st == sMdrLoad);
        checkPcSrc(pcSrc, expPcSrc(st));
        checkBit("epcWrite", epcWrite, st == sExcSave);
        checkCause(excCause, (st == sExcSave && cls == clsIllegal) ? causeIllegal : causeOverflow);
    endtask

    task automatic applyInstruction();
        logic [31:0] pick;
        logic [31:0] rnd;
        logic [31:0] bad;
        pick       = randomBits(4);
        rnd        = randomBits(6);
        bad        = randomBits(2);
        opcode     = opTable[pick[3:0]];
        funct      = rnd[5:0]; // don't care outside r-type
        modelClass = clsTable[pick[3:0]];
        if (pick[3:0] < 3) begin
            funct = fnTable[pick[1:0]];
        end else if (pick[3:0] == 15) begin
            opcode = badOp[bad[1:0]];
            if (bad[1]) begin
                funct = badFn[bad[0]];
            end
        end
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        failRun($sformatf("the run did not finish within %0d clock cycles", CYCLE_LIMIT));
    end

    initial begin : stimulus
        logic [31:0] ovBit;
        ctrlState_t  nextState;
        rstN       = 1'b0;
        opcode     = `OP_RTYPE;
        funct      = `FN_ADD;
        overflow   = 1'b0;
        lfsrState  = 32'h6922;
        modelState = sReset;
        modelClass = clsAddR;
        doneCount  = 0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            checkOutputs();
        end
        rstN       = 1'b1;
        modelState = sFetch; // first edge after release
        while (doneCount < NUM_INSTR) begin
            @(negedge clk);
            checkOutputs();
            if (irWrite) applyInstruction(); // IR takes it at the next edge
            ovBit     = randomBits(1);
            overflow  = ovBit[0];
            nextState = modelNext(modelState, modelClass, overflow);
            if (nextState == sFetch) doneCount++;
            modelState = nextState;
        end
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+common
+incdir+sim
common/mipsCtrlPkg.sv
logic/opcodeDecoder.sv
control/ctrlSequencer.sv
control/ctrlSignalEncoder.sv
control/controlUnit.sv
sim/controlUnitTb.sv
